//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - hdl

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_req_gen.sv
  - hdl/lsu_ctrl_fifo.sv
  - hdl/lsu_rdata_align.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - bench/lsu_mem_model.sv
      - bench/lsu_tb.sv

//--- bench/lsu_mem_model.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_mem_model import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      data_req_i,
  input  lsu_word_t data_addr_i,
  input  logic      data_we_i,
  input  lsu_be_t   data_be_i,
  input  lsu_word_t data_wdata_i,
  output logic      data_gnt_o,
  output logic      data_rvalid_o,
  output lsu_word_t data_rdata_o
);

  logic [7:0] mem [64];        // byte memory, address bits 5:0
  integer     seed;
  integer     cyc;             // edge counter for response timing
  integer     base;
  lsu_word_t  rsp_data_q [$];  // responses in grant order
  integer     rsp_due_q [$];   // edge at which each may be returned

  initial begin
    seed = 98247;
    for (int i = 0; i < 64; i++) begin
      mem[i] = $random(seed);  // low byte of each draw
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_gnt_o    <= 1'b0;
      data_rvalid_o <= 1'b0;
      data_rdata_o  <= '0;
      rsp_data_q.delete();
      rsp_due_q.delete();
      cyc = 0;
    end else begin
      cyc = cyc + 1;
      if (data_req_i && data_gnt_o) begin
        base = data_addr_i[5:2] * 4;
        if (data_we_i) begin
          for (int b = 0; b < `LSU_BE_W; b++) begin
            if (data_be_i[b]) mem[base + b] = data_wdata_i[8*b +: 8];
          end
          rsp_data_q.push_back('0);  // writes carry no data
        end else begin
          rsp_data_q.push_back({mem[base+3], mem[base+2], mem[base+1], mem[base]});
        end
        rsp_due_q.push_back(cyc + 1 + (($random(seed) & 3) % 3));  // 1 to 3 cycles
      end
      // oldest response first
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
        data_rvalid_o <= 1'b1;
        data_rdata_o  <= rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        data_rvalid_o <= 1'b0;
      end
      data_gnt_o <= (($random(seed) & 3) != 0);  // grant about 3 of 4 cycles
    end
  end

endmodule

//--- bench/lsu_tb.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int NUM_OPS = 300;
  localparam int RST_CYC = 5;
  localparam int LIMIT   = NUM_OPS * 12 + RST_CYC;

  logic       clk;
  logic       rst_n;
  logic       req_ex, we_ex, useincr;
  lsu_type_e  type_ex;
  lsu_ext_e   ext_ex;
  lsu_word_t  wdata_ex, op_a, op_b;
  logic [1:0] reg_off_ex;
  lsu_word_t  rdata_ex, data_addr, data_wdata, data_rdata;
  logic       ready_ex, ready_wb, busy, data_req, data_we, data_gnt, data_rvalid;
  lsu_be_t    data_be;

  integer     seed;
  integer     mseed;
  integer     cyc;
  integer     val_errors;
  integer     proto_errors;
  integer     outstanding;            // grants minus rvalids
  logic [7:0] model_mem [64];         // reference copy of the memory
  logic       exp_is_load [$];        // one entry per accepted transfer
  lsu_word_t  exp_val [$];
  lsu_word_t  last_load;
  lsu_word_t  tgt_addr;               // address the current op aims at

  lsu_top dut_i (
    .clk (clk), .rst_n (rst_n),
    .data_req_ex_i (req_ex), .data_we_ex_i (we_ex), .data_type_ex_i (type_ex),
    .data_sign_ext_ex_i (ext_ex), .data_wdata_ex_i (wdata_ex),
    .data_reg_offset_ex_i (reg_off_ex), .operand_a_ex_i (op_a), .operand_b_ex_i (op_b),
    .addr_useincr_ex_i (useincr), .data_rdata_ex_o (rdata_ex),
    .lsu_ready_ex_o (ready_ex), .lsu_ready_wb_o (ready_wb), .busy_o (busy),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_addr_o (data_addr),
    .data_we_o (data_we), .data_be_o (data_be), .data_wdata_o (data_wdata),
    .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata)
  );

  lsu_mem_model u_mem (
    .clk (clk), .rst_n (rst_n), .data_req_i (data_req), .data_addr_i (data_addr),
    .data_we_i (data_we), .data_be_i (data_be), .data_wdata_i (data_wdata),
    .data_gnt_o (data_gnt), .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////
  // reference rules

  function automatic lsu_be_t exp_be(lsu_type_e t, logic [1:0] off);
    if (t == LSU_WORD) begin
      case (off)
        2'd0:    return lsu_be_t'(4'b1111);
        2'd1:    return lsu_be_t'(4'b1110);
        2'd2:    return lsu_be_t'(4'b1100);
        default: return lsu_be_t'(4'b1000);  // upper lanes drop off
      endcase
    end
    if (t == LSU_HALF) begin
      case (off)
        2'd0:    return lsu_be_t'(4'b0011);
        2'd1:    return lsu_be_t'(4'b0110);
        2'd2:    return lsu_be_t'(4'b1100);
        default: return lsu_be_t'(4'b1000);  // upper lane drops off
      endcase
    end
    return lsu_be_t'(4'b0001 << off);
  endfunction

  // register byte (k - rot) lands on lane k
  function automatic lsu_word_t rotate_store(lsu_word_t w, logic [1:0] off, logic [1:0] reg_off);
    logic [1:0] rot;
    lsu_word_t  res;
    rot = off - reg_off;
    for (int k = 0; k < 4; k++) res[8*k +: 8] = w[8*((k - rot + 4) % 4) +: 8];
    return res;
  endfunction

  function automatic lsu_word_t load_value(lsu_type_e t, lsu_ext_e e, int a);
    logic [15:0] h;
    logic [7:0]  b;
    logic        fill;
    h = {model_mem[a+1], model_mem[a]};  // a+1 stays inside for aligned halves
    b = model_mem[a];
    if (t == LSU_WORD) return {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
    if (t == LSU_HALF) fill = (e == LSU_EXT_ZERO) ? 1'b0 : (e == LSU_EXT_ONES) ? 1'b1 : h[15];
    else               fill = (e == LSU_EXT_ZERO) ? 1'b0 : (e == LSU_EXT_ONES) ? 1'b1 : b[7];
    if (t == LSU_HALF) return {{16{fill}}, h};
    return {{24{fill}}, b};
  endfunction

  task automatic check_word(string name, lsu_word_t exp, lsu_word_t act);
    if (exp !== act) begin
      val_errors++;
      $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_be(string name, lsu_be_t exp, lsu_be_t act);
    if (exp !== act) begin
      val_errors++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_idle(string when);
    check_word({"busy ", when}, '0, lsu_word_t'(busy));
    check_word({"wb ready ", when}, lsu_word_t'(1), lsu_word_t'(ready_wb));
    check_word({"ex ready ", when}, lsu_word_t'(1), lsu_word_t'(ready_ex));
  endtask

  ////////////////////
  // bus monitor and model

  always @(posedge clk) begin
    lsu_word_t exp_addr;
    lsu_word_t rot;
    lsu_word_t mask;
    lsu_be_t   be;
    integer    a;
    if (rst_n) begin
      if (outstanding >= `LSU_DEPTH && data_req) begin
        proto_errors++;
        $display("request raised while %0d transfers were outstanding", outstanding);
      end
      if (data_req && data_gnt) begin
        exp_addr = tgt_addr;  // a + b or a, built by the stimulus
        check_word("address", exp_addr, data_addr);
        check_word("write flag", lsu_word_t'(we_ex), lsu_word_t'(data_we));
        a = exp_addr[5:0];
        if (we_ex) begin
          be = exp_be(type_ex, a[1:0]);
          check_be("store byte enables", be, data_be);
          rot = rotate_store(wdata_ex, a[1:0], reg_off_ex);
          for (int k = 0; k < 4; k++) mask[8*k +: 8] = {8{be[k]}};
          check_word("store data", rot & mask, data_wdata & mask);
          for (int k = 0; k < 4; k++) begin
            if (be[k]) model_mem[(a & 60) + k] = rot[8*k +: 8];
          end
          exp_is_load.push_back(1'b0);
          exp_val.push_back('0);
        end else begin
          exp_is_load.push_back(1'b1);
          exp_val.push_back(load_value(type_ex, ext_ex, a));
        end
        outstanding++;
      end
      if (data_rvalid) begin
        if (exp_val.size() == 0) begin
          proto_errors++;
          $display("response arrived with no transfer outstanding");
        end else if (exp_is_load.pop_front()) begin
          last_load = exp_val.pop_front();
          check_word("load data", last_load, rdata_ex);
        end else begin
          void'(exp_val.pop_front());
          check_word("held load data", last_load, rdata_ex);  // store response
        end
        outstanding--;
      end else begin
        check_word("held load data", last_load, rdata_ex);  // between responses
      end
    end
  end

  ////////////////////
  // stimulus

  task automatic issue_op();
    logic       is_store;
    logic       inc;
    lsu_type_e  t;
    lsu_word_t  addr, b, hi;
    logic [5:0] target;
    is_store = (($random(seed) & 7) < 3);
    t        = lsu_type_e'($random(seed) & 3);
    target   = $random(seed);
    if (!is_store && t == LSU_WORD) target[1:0] = 2'b00;  // loads naturally aligned
    if (!is_store && t == LSU_HALF) target[0]   = 1'b0;
    hi   = $random(seed);
    addr = {hi[31:6], target};
    b    = $random(seed) & 255;
    inc  = $random(seed);
    tgt_addr   <= addr;
    op_b       <= b;
    op_a       <= inc ? addr - b : addr;
    useincr    <= inc;
    we_ex      <= is_store;
    type_ex    <= t;
    ext_ex     <= lsu_ext_e'($random(seed) & 3);
    wdata_ex   <= $random(seed);
    reg_off_ex <= $random(seed);
    req_ex     <= 1'b1;
  endtask

  always @(posedge clk) begin
    cyc++;
    if (cyc > LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    seed = 98247;
    mseed = 98247;  // same sequence as the memory fill
    cyc = 0;
    val_errors = 0;
    proto_errors = 0;
    outstanding = 0;
    last_load = '0;
    tgt_addr = '0;
    req_ex = 1'b0;
    we_ex = 1'b0;
    useincr = 1'b0;
    type_ex = LSU_WORD;
    ext_ex = LSU_EXT_ZERO;
    wdata_ex = '0;
    op_a = '0;
    op_b = '0;
    reg_off_ex = '0;
    for (int i = 0; i < 64; i++) model_mem[i] = $random(mseed);
    rst_n = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    check_idle("after reset");
    for (int n = 0; n < NUM_OPS; n++) begin
      issue_op();
      do @(posedge clk); while (!ready_ex);  // EX moves on when ready
    end
    req_ex <= 1'b0;
    do @(posedge clk); while (busy);
    @(posedge clk);
    check_idle("after drain");
    $display("errors: %0d value mismatches, %0d protocol errors", val_errors, proto_errors);
    if (val_errors + proto_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data path width, also used for the address
`define LSU_DATA_W 32

// byte lanes on the data bus
`define LSU_BE_W 4

// max transfers in flight between grant and rvalid
`define LSU_DEPTH 2

`endif

//--- hdl/lsu_ctrl_fifo.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_ctrl_fifo import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      push_i,          // accepted transfer
  input  lsu_ctrl_t push_ctrl_i,     // its control entry
  input  logic      req_pending_i,   // request on the bus
  input  logic      data_req_ex_i,   // EX wants an access
  input  logic      data_rvalid_i,   // response, pops the head

  output logic      room_o,          // another transfer may be issued
  output lsu_ctrl_t head_ctrl_o,     // entry of the oldest transfer
  output logic      lsu_ready_ex_o,
  output logic      lsu_ready_wb_o,
  output logic      busy_o
);

  localparam int PTR_W = (`LSU_DEPTH > 1) ? $clog2(`LSU_DEPTH) : 1;
  localparam int CNT_W = $clog2(`LSU_DEPTH + 1);

  lsu_ctrl_t        ctrl_mem [`LSU_DEPTH];  // one entry per transfer in flight
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fill_q;                 // entries in flight
  logic             empty;
  logic             full;

  assign empty = (fill_q == '0);
  assign full  = (fill_q == CNT_W'(`LSU_DEPTH));

  ////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (push_i) begin
      ctrl_mem[wr_ptr_q] <= push_ctrl_i;
    end
  end

  assign head_ctrl_o = ctrl_mem[rd_ptr_q];

  ////////////////////
  // pointers and fill

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`LSU_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (data_rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`LSU_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, data_rvalid_i})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;  // none, or push and pop together
      endcase
    end
  end

  ////////////////////
  // ready / busy

  assign room_o = ~full;

  // WB idle, or the awaited response is here
  assign lsu_ready_wb_o = empty ? 1'b1 : data_rvalid_i;

  // EX and WB advance in lock step once WB is occupied
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;                  // nothing to do
    end else if (empty) begin
      lsu_ready_ex_o = push_i;
    end else if (!full) begin
      lsu_ready_ex_o = push_i & data_rvalid_i;
    end else begin
      lsu_ready_ex_o = data_rvalid_i;         // no issue possible while full
    end
  end

  assign busy_o = ~empty | req_pending_i;

endmodule

//--- hdl/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

  typedef logic [`LSU_DATA_W-1:0] lsu_word_t;  // address or data word
  typedef logic [`LSU_BE_W-1:0]   lsu_be_t;    // one bit per byte lane

  // access size, both byte codes behave the same
  typedef enum logic [1:0] {
    LSU_WORD    = 2'b00,
    LSU_HALF    = 2'b01,
    LSU_BYTE    = 2'b10,
    LSU_BYTE_HI = 2'b11
  } lsu_type_e;

  // load extension mode
  typedef enum logic [1:0] {
    LSU_EXT_ZERO    = 2'b00,
    LSU_EXT_SIGN    = 2'b01,
    LSU_EXT_ONES    = 2'b10,
    LSU_EXT_SIGN_HI = 2'b11  // also sign
  } lsu_ext_e;

  // per-transaction control entry, 7 bits
  // offset is the byte address within the word
  typedef struct packed {
    logic      we;      // store when set
    lsu_type_e dtype;   // access size
    logic [1:0] offset; // addr[1:0] of the access
    lsu_ext_e  ext;     // extension for loads
  } lsu_ctrl_t;

endpackage

//--- hdl/lsu_rdata_align.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_rdata_align import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      data_rvalid_i,   // response strobe
  input  lsu_word_t data_rdata_i,    // raw bus word
  input  lsu_ctrl_t head_ctrl_i,     // entry of the responding transfer

  output lsu_word_t data_rdata_ex_o  // aligned and extended load data
);

  lsu_word_t   lane_word;   // bus word shifted down to the access
  logic [15:0] lane_half;
  logic [7:0]  lane_byte;
  logic        fill_bit;    // value for the upper bits
  lsu_word_t   rdata_ext;   // extended result
  lsu_word_t   rdata_q;     // last load result
  logic        load_resp;   // rvalid belongs to a load

  ////////////////////
  // lane select

  // loads are naturally aligned, so a plain shift finds the lane
  assign lane_word = data_rdata_i >> {head_ctrl_i.offset, 3'b000};
  assign lane_half = lane_word[15:0];
  assign lane_byte = lane_word[7:0];

  ////////////////////
  // extension

  always_comb begin
    case (head_ctrl_i.ext)
      LSU_EXT_ZERO: fill_bit = 1'b0;
      LSU_EXT_ONES: fill_bit = 1'b1;
      LSU_EXT_SIGN, LSU_EXT_SIGN_HI: begin
        // msb of the selected lane
        fill_bit = (head_ctrl_i.dtype == LSU_HALF) ? lane_half[15] : lane_byte[7];
      end
      default: fill_bit = 1'b0;
    endcase
  end

  always_comb begin
    case (head_ctrl_i.dtype)
      LSU_WORD:              rdata_ext = data_rdata_i;  // unchanged
      LSU_HALF:              rdata_ext = {{(`LSU_DATA_W-16){fill_bit}}, lane_half};
      LSU_BYTE, LSU_BYTE_HI: rdata_ext = {{(`LSU_DATA_W-8){fill_bit}}, lane_byte};
      default:               rdata_ext = data_rdata_i;
    endcase
  end

  ////////////////////
  // hold last result

  assign load_resp = data_rvalid_i & ~head_ctrl_i.we;  // store responses ignored

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (load_resp) begin
      rdata_q <= rdata_ext;
    end
  end

  // live value in the response cycle, held value after
  assign data_rdata_ex_o = load_resp ? rdata_ext : rdata_q;

endmodule

//--- hdl/lsu_req_gen.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_req_gen import lsu_pkg::*; (
  // EX stage side
  input  logic       data_req_ex_i,        // access requested
  input  logic       data_we_ex_i,         // store
  input  lsu_type_e  data_type_ex_i,       // word / half / byte
  input  lsu_ext_e   data_sign_ext_ex_i,   // extension mode for loads
  input  lsu_word_t  data_wdata_ex_i,      // store data as held in the register
  input  logic [1:0] data_reg_offset_ex_i, // byte offset inside the register
  input  lsu_word_t  operand_a_ex_i,       // base
  input  lsu_word_t  operand_b_ex_i,       // increment
  input  logic       addr_useincr_ex_i,    // a + b instead of a

  // from the control fifo
  input  logic       room_i,               // fewer than DEPTH in flight

  // data bus
  input  logic       data_gnt_i,
  output logic       data_req_o,
  output lsu_word_t  data_addr_o,
  output logic       data_we_o,
  output lsu_be_t    data_be_o,
  output lsu_word_t  data_wdata_o,

  // to the control fifo
  output logic       trans_acc_o,          // request accepted this cycle
  output lsu_ctrl_t  trans_ctrl_o          // entry for the accepted access
);

  lsu_word_t                addr;          // effective address
  logic [1:0]               addr_off;      // byte within word
  logic [1:0]               wdata_off;     // rotation in bytes
  lsu_be_t                  be_mask;       // lanes for offset 0
  logic [2*`LSU_DATA_W-1:0] wdata_dbl;     // doubled word for rotation

  ////////////////////
  // address

  assign addr     = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign addr_off = addr[1:0];

  ////////////////////
  // byte enables

  // base pattern per size, shifted up by the offset
  // lanes past the top of the word fall off (aligned table)
  always_comb begin
    case (data_type_ex_i)
      LSU_WORD:              be_mask = '1;
      LSU_HALF:              be_mask = lsu_be_t'(2'b11);
      LSU_BYTE, LSU_BYTE_HI: be_mask = lsu_be_t'(1'b1);
      default:               be_mask = '1;
    endcase
  end

  assign data_be_o = be_mask << addr_off;

  ////////////////////
  // store data

  // move register byte reg_offset onto bus lane addr_off
  assign wdata_off    = addr_off - data_reg_offset_ex_i;  // wraps mod 4
  assign wdata_dbl    = {data_wdata_ex_i, data_wdata_ex_i} << {wdata_off, 3'b000};
  assign data_wdata_o = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W]; // upper half = rotl

  // bus request, held as long as EX holds its request
  assign data_req_o  = data_req_ex_i & room_i;
  assign data_addr_o = addr;
  assign data_we_o   = data_we_ex_i;

  assign trans_acc_o = data_req_o & data_gnt_i;  // req and gnt together

  // what the response side needs later
  assign trans_ctrl_o = '{
    we:     data_we_ex_i,
    dtype:  data_type_ex_i,
    offset: addr_off,
    ext:    data_sign_ext_ex_i
  };

endmodule

//--- hdl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // EX stage
  input  logic       data_req_ex_i,
  input  logic       data_we_ex_i,
  input  lsu_type_e  data_type_ex_i,
  input  lsu_ext_e   data_sign_ext_ex_i,
  input  lsu_word_t  data_wdata_ex_i,
  input  logic [1:0] data_reg_offset_ex_i,
  input  lsu_word_t  operand_a_ex_i,
  input  lsu_word_t  operand_b_ex_i,
  input  logic       addr_useincr_ex_i,
  output lsu_word_t  data_rdata_ex_o,
  output logic       lsu_ready_ex_o,
  output logic       lsu_ready_wb_o,
  output logic       busy_o,

  // data bus
  output logic       data_req_o,
  input  logic       data_gnt_i,
  output lsu_word_t  data_addr_o,
  output logic       data_we_o,
  output lsu_be_t    data_be_o,
  output lsu_word_t  data_wdata_o,
  input  logic       data_rvalid_i,
  input  lsu_word_t  data_rdata_i
);

  logic      trans_acc;   // req and gnt in the same cycle
  lsu_ctrl_t trans_ctrl;  // entry of the accepted access
  logic      room;        // fifo not full
  lsu_ctrl_t head_ctrl;   // entry of the oldest access

  // request side
  lsu_req_gen u_req_gen (
    .data_req_ex_i        (data_req_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .room_i               (room),
    .data_gnt_i           (data_gnt_i),
    .data_req_o           (data_req_o),
    .data_addr_o          (data_addr_o),
    .data_we_o            (data_we_o),
    .data_be_o            (data_be_o),
    .data_wdata_o         (data_wdata_o),
    .trans_acc_o          (trans_acc),
    .trans_ctrl_o         (trans_ctrl)
  );

  // transfers in flight
  lsu_ctrl_fifo u_ctrl_fifo (
    .clk            (clk),
    .rst_n          (rst_n),
    .push_i         (trans_acc),
    .push_ctrl_i    (trans_ctrl),
    .req_pending_i  (data_req_o),
    .data_req_ex_i  (data_req_ex_i),
    .data_rvalid_i  (data_rvalid_i),
    .room_o         (room),
    .head_ctrl_o    (head_ctrl),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  // response side
  lsu_rdata_align u_rdata_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .head_ctrl_i     (head_ctrl),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

endmodule

//--- vlog.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_req_gen.sv
hdl/lsu_ctrl_fifo.sv
hdl/lsu_rdata_align.sv
hdl/lsu_top.sv
bench/lsu_mem_model.sv
bench/lsu_tb.sv
